/* common/gremlin_pkg.sv */
package gremlin_pkg;

  // ----------------------------------------
  // field widths
  // ----------------------------------------
  typedef logic        slot_t;        // 1 Gbps slot 0 or 1
  typedef logic [1:0]  section_t;     // enable section 0..3
  typedef logic [5:0]  count_t;       // blocks requested or sent
  typedef logic [19:0] page_t;        // mcu page address
  typedef logic [11:0] start_t;       // first block of the move
  typedef logic [63:0] host_word_t;   // host write data
  typedef logic [31:0] host_rdata_t;  // host read data

  // ----------------------------------------
  // transfer descriptor
  // ----------------------------------------
  // Field order matches host word bits 63:22 one to one, so the
  // descriptor is the top 42 bits of the host word.
  typedef struct packed {
    page_t    page;     // host bits 63:44
    start_t   start;    // host bits 43:32
    count_t   count;    // host bits 31:26
    section_t section;  // host bits 25:24
    logic     rd_op;    // memory read direction
    logic     on_data;  // selects the data half of memory
  } desc_t;

  // ----------------------------------------
  // completion status
  // ----------------------------------------
  typedef struct packed {
    count_t sent;       // blocks the mover actually moved
    logic   mover_irq;
    logic   abort;      // abrupt stop or device error
  } stat_t;

  // ----------------------------------------
  // scheduler states
  // ----------------------------------------
  typedef enum logic [2:0] {
    S_IDLE,   // waiting for a slot tick with a pending descriptor
    S_LOAD,   // descriptor loaded, set up request
    S_REQ,    // waiting for alignment grant
    S_RUN,    // mover busy
    S_DONE    // status capture cycle
  } sched_state_t;

endpackage

/* scheduler/carousel_timer.sv */
`timescale 1ns/100ps

module carousel_timer
#(
  parameter int SMALL_PERIOD = 192,
  parameter int SLOT1_TICK   = 96
)
(
  input  logic CLK,
  input  logic RST,
  output logic tick_slot0_o,
  output logic tick_slot1_o,
  output logic rfrs_window_o
);

  localparam int SW = $clog2(SMALL_PERIOD);

  logic [SW-1:0] small_q;
  logic [3:0]    big_q;
  logic          small_wrap;

  assign small_wrap = (small_q == SW'(SMALL_PERIOD - 1));

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      small_q <= SW'(1);  // slot 0 waits one full period
      big_q   <= 4'd0;
    end
    else if (small_wrap)
    begin
      small_q <= '0;
      big_q   <= big_q + 4'd1;  // one big step per small period
    end
    else
      small_q <= small_q + 1'b1;
  end

  assign tick_slot0_o  = (small_q == '0);
  assign tick_slot1_o  = (small_q == SW'(SLOT1_TICK));
  assign rfrs_window_o = tick_slot0_o && big_q[0];  // odd big periods only

endmodule

/* scheduler/xfer_sched_fsm.sv */
`timescale 1ns/100ps

module xfer_sched_fsm
(
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    tick_slot0_i,
  input  logic                    tick_slot1_i,
  input  logic                    rfrs_window_i,
  input  gremlin_pkg::desc_t      desc0_i,
  input  gremlin_pkg::desc_t      desc1_i,
  input  logic [1:0]              pending_i,
  input  logic [1:0]              mcu_grant_align_i,
  input  logic                    blck_working_i,
  output logic                    taken_o,
  output gremlin_pkg::slot_t      taken_slot_o,
  output gremlin_pkg::start_t     blck_start_o,
  output gremlin_pkg::count_t     blck_count_req_o,
  output gremlin_pkg::section_t   blck_section_o,
  output logic                    blck_issue_o,
  output logic [1:0]              rst_mvblck_o,
  output gremlin_pkg::page_t      mcu_page_addr_o,
  output logic [1:0]              mcu_req_align_o,
  output logic                    mcu_refresh_stb_o,
  output logic                    done_o,
  output gremlin_pkg::slot_t      done_slot_o,
  output gremlin_pkg::section_t   done_section_o
);

  gremlin_pkg::sched_state_t state_q;
  gremlin_pkg::desc_t        cur_q;
  gremlin_pkg::desc_t        take_desc;
  gremlin_pkg::slot_t        slot_q;
  gremlin_pkg::slot_t        take_slot;
  logic                      take_now;
  logic                      issue_new;
  logic                      working_prev;
  logic                      working_fall;
  logic                      granted;
  logic [7:0]                rfrs_req;  // wide enough for long busy stretches
  logic [7:0]                rfrs_ack;
  logic                      rfrs_grant;

  // slot whose tick is now and which has work
  always_comb
  begin
    take_now  = 1'b0;
    take_slot = 1'b0;
    if (state_q == gremlin_pkg::S_IDLE)
    begin
      if (tick_slot0_i && pending_i[0])
        take_now = 1'b1;
      else if (tick_slot1_i && pending_i[1])
      begin
        take_now  = 1'b1;
        take_slot = 1'b1;
      end
    end
  end

  assign take_desc    = take_slot ? desc1_i : desc0_i;
  assign taken_o      = take_now;
  assign taken_slot_o = take_slot;
  assign granted      = |(mcu_req_align_o & mcu_grant_align_i);
  assign working_fall = working_prev && !blck_working_i;
  assign rfrs_grant   = (rfrs_req != rfrs_ack) && (state_q == gremlin_pkg::S_IDLE) &&
                        (pending_i == 2'b00);

  // mover and mcu fields follow the loaded descriptor
  assign blck_start_o     = cur_q.start;
  assign blck_count_req_o = cur_q.count;
  assign blck_section_o   = cur_q.section;
  assign mcu_page_addr_o  = cur_q.page;
  assign done_o           = (state_q == gremlin_pkg::S_DONE);
  assign done_slot_o      = slot_q;
  assign done_section_o   = cur_q.section;

  always_ff @(posedge CLK)
  begin
    if (take_now)
    begin
      cur_q  <= take_desc;
      slot_q <= take_slot;
    end
  end

  // ----------------------------------------
  // transfer sequencing and refresh
  // ----------------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state_q           <= gremlin_pkg::S_IDLE;
      issue_new         <= 1'b0;
      blck_issue_o      <= 1'b0;
      working_prev      <= 1'b0;
      mcu_req_align_o   <= 2'b00;
      rst_mvblck_o      <= 2'b00;
      mcu_refresh_stb_o <= 1'b0;
      rfrs_req          <= 8'd0;
      rfrs_ack          <= 8'd0;
    end
    else
    begin
      working_prev <= blck_working_i;

      if (rfrs_window_i)
        rfrs_req <= rfrs_req + 8'd1;
      if (rfrs_grant)
      begin
        rfrs_ack          <= rfrs_ack + 8'd1;
        mcu_refresh_stb_o <= !mcu_refresh_stb_o;
      end

      case (state_q)
        gremlin_pkg::S_IDLE:
          if (take_now)
          begin
            rst_mvblck_o <= {take_desc.rd_op, !take_desc.rd_op};
            state_q      <= gremlin_pkg::S_LOAD;
          end
        gremlin_pkg::S_LOAD:
        begin
          issue_new       <= !issue_new;
          mcu_req_align_o <= {cur_q.on_data, !cur_q.on_data};  // one-hot half select
          state_q         <= gremlin_pkg::S_REQ;
        end
        gremlin_pkg::S_REQ:
          if (granted)
          begin
            blck_issue_o <= issue_new;  // toggles the mover strobe
            state_q      <= gremlin_pkg::S_RUN;
          end
        gremlin_pkg::S_RUN:
          if (working_fall)
          begin
            mcu_req_align_o <= 2'b00;
            state_q         <= gremlin_pkg::S_DONE;
          end
        gremlin_pkg::S_DONE:
        begin
          rst_mvblck_o <= 2'b00;
          state_q      <= gremlin_pkg::S_IDLE;
        end
        default:
          state_q <= gremlin_pkg::S_IDLE;
      endcase
    end
  end

endmodule

/* design/host_regs.sv */
`timescale 1ns/100ps

module host_regs
(
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      write_cpu_i,
  input  logic                      read_cpu_i,
  input  logic                      addr_cpu_i,
  input  gremlin_pkg::host_word_t   in_cpu_i,
  input  logic                      taken_i,
  input  gremlin_pkg::slot_t        taken_slot_i,
  input  gremlin_pkg::stat_t        stat0_i,
  input  gremlin_pkg::stat_t        stat1_i,
  output logic                      write_ack_o,
  output logic                      read_ack_o,
  output gremlin_pkg::host_rdata_t  read_data_o,
  output gremlin_pkg::desc_t        desc0_o,
  output gremlin_pkg::desc_t        desc1_o,
  output logic [1:0]                pending_o
);

  logic                write_r;
  logic                read_r;
  logic                write_edge;
  logic                read_edge;
  gremlin_pkg::slot_t  wr_slot;
  gremlin_pkg::desc_t  wr_desc;
  gremlin_pkg::stat_t  rd_stat;
  gremlin_pkg::desc_t  bank_q [2];
  logic [1:0]          pending_q;

  assign write_edge = write_cpu_i && !write_r;  // rising edge only
  assign read_edge  = read_cpu_i && !read_r;
  assign wr_slot    = in_cpu_i[0];
  assign rd_stat    = addr_cpu_i ? stat1_i : stat0_i;

  // unpack host word into descriptor fields
  always_comb
  begin
    wr_desc.page    = in_cpu_i[63:44];
    wr_desc.start   = in_cpu_i[43:32];
    wr_desc.count   = in_cpu_i[31:26];
    wr_desc.section = in_cpu_i[25:24];
    wr_desc.rd_op   = in_cpu_i[23];
    wr_desc.on_data = in_cpu_i[22];
  end

  // ----------------------------------------
  // descriptor bank
  // ----------------------------------------
  always_ff @(posedge CLK)
  begin
    if (write_edge)
      bank_q[wr_slot] <= wr_desc;  // overwrites a still pending slot
  end

  assign desc0_o   = bank_q[0];
  assign desc1_o   = bank_q[1];
  assign pending_o = pending_q;

  // ----------------------------------------
  // strobes, pending flags, read data
  // ----------------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      write_r     <= 1'b1;  // no edge straight out of reset
      read_r      <= 1'b1;
      write_ack_o <= 1'b0;
      read_ack_o  <= 1'b0;
      read_data_o <= '0;
      pending_q   <= 2'b00;
    end
    else
    begin
      write_r     <= write_cpu_i;
      read_r      <= read_cpu_i;
      write_ack_o <= write_edge;  // one cycle after the edge
      read_ack_o  <= read_edge;

      if (taken_i)
        pending_q[taken_slot_i] <= 1'b0;
      if (write_edge)
        pending_q[wr_slot] <= 1'b1;  // new write wins over a take

      if (read_edge)
        read_data_o <= {23'd0, pending_q[addr_cpu_i], rd_stat};
    end
  end

endmodule

/* design/status_capture.sv */
`timescale 1ns/100ps

module status_capture
(
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   done_i,
  input  gremlin_pkg::slot_t     done_slot_i,
  input  gremlin_pkg::section_t  done_section_i,
  input  gremlin_pkg::stat_t     mover_stat_i,
  output gremlin_pkg::stat_t     stat0_o,
  output gremlin_pkg::stat_t     stat1_o,
  output logic [3:0]             en_stb_o
);

  gremlin_pkg::stat_t stat_q [2];

  // ----------------------------------------
  // per-slot status and section toggles
  // ----------------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      stat_q[0] <= '0;
      stat_q[1] <= '0;
      en_stb_o  <= 4'b0000;
    end
    else if (done_i)
    begin
      stat_q[done_slot_i]      <= mover_stat_i;  // last completion of the slot
      en_stb_o[done_section_i] <= !en_stb_o[done_section_i];
    end
  end

  assign stat0_o = stat_q[0];
  assign stat1_o = stat_q[1];

endmodule

/* design/gremlin_top.sv */
`timescale 1ns/100ps

module gremlin_top
#(
  parameter int SMALL_PERIOD = 192,
  parameter int SLOT1_TICK   = 96
)
(
  input  logic                      CLK,
  input  logic                      RST,
  // host
  input  logic                      write_cpu_i,
  input  logic                      read_cpu_i,
  input  logic                      addr_cpu_i,
  input  gremlin_pkg::host_word_t   in_cpu_i,
  output logic                      write_ack_o,
  output logic                      read_ack_o,
  output gremlin_pkg::host_rdata_t  read_data_o,
  // block mover
  output gremlin_pkg::start_t       blck_start_o,
  output gremlin_pkg::count_t       blck_count_req_o,
  output gremlin_pkg::section_t     blck_section_o,
  output logic                      blck_issue_o,
  output logic [1:0]                rst_mvblck_o,
  input  gremlin_pkg::count_t       blck_count_sent_i,
  input  logic                      blck_working_i,
  input  logic                      blck_irq_i,
  input  logic                      blck_abort_i,
  // mcu
  output gremlin_pkg::page_t        mcu_page_addr_o,
  output logic [1:0]                mcu_req_align_o,
  input  logic [1:0]                mcu_grant_align_i,
  output logic                      mcu_refresh_stb_o,
  // section enables
  output logic [3:0]                en_stb_o
);

  gremlin_pkg::desc_t     desc0;
  gremlin_pkg::desc_t     desc1;
  logic [1:0]             pending;
  logic                   taken;
  gremlin_pkg::slot_t     taken_slot;
  logic                   tick_slot0;
  logic                   tick_slot1;
  logic                   rfrs_window;
  logic                   done;
  gremlin_pkg::slot_t     done_slot;
  gremlin_pkg::section_t  done_section;
  gremlin_pkg::stat_t     stat0;
  gremlin_pkg::stat_t     stat1;
  gremlin_pkg::stat_t     mover_stat;

  assign mover_stat = '{sent: blck_count_sent_i, mover_irq: blck_irq_i, abort: blck_abort_i};

  host_regs host_regs_i (
    .CLK (CLK), .RST (RST),
    .write_cpu_i (write_cpu_i), .read_cpu_i (read_cpu_i),
    .addr_cpu_i (addr_cpu_i), .in_cpu_i (in_cpu_i),
    .taken_i (taken), .taken_slot_i (taken_slot),
    .stat0_i (stat0), .stat1_i (stat1),
    .write_ack_o (write_ack_o), .read_ack_o (read_ack_o),
    .read_data_o (read_data_o),
    .desc0_o (desc0), .desc1_o (desc1), .pending_o (pending)
  );

  carousel_timer #(
    .SMALL_PERIOD (SMALL_PERIOD),
    .SLOT1_TICK   (SLOT1_TICK)
  ) carousel_timer_i (
    .CLK (CLK), .RST (RST),
    .tick_slot0_o (tick_slot0), .tick_slot1_o (tick_slot1),
    .rfrs_window_o (rfrs_window)
  );

  xfer_sched_fsm xfer_sched_fsm_i (
    .CLK (CLK), .RST (RST),
    .tick_slot0_i (tick_slot0), .tick_slot1_i (tick_slot1),
    .rfrs_window_i (rfrs_window),
    .desc0_i (desc0), .desc1_i (desc1), .pending_i (pending),
    .mcu_grant_align_i (mcu_grant_align_i), .blck_working_i (blck_working_i),
    .taken_o (taken), .taken_slot_o (taken_slot),
    .blck_start_o (blck_start_o), .blck_count_req_o (blck_count_req_o),
    .blck_section_o (blck_section_o), .blck_issue_o (blck_issue_o),
    .rst_mvblck_o (rst_mvblck_o),
    .mcu_page_addr_o (mcu_page_addr_o), .mcu_req_align_o (mcu_req_align_o),
    .mcu_refresh_stb_o (mcu_refresh_stb_o),
    .done_o (done), .done_slot_o (done_slot), .done_section_o (done_section)
  );

  status_capture status_capture_i (
    .CLK (CLK), .RST (RST),
    .done_i (done), .done_slot_i (done_slot), .done_section_i (done_section),
    .mover_stat_i (mover_stat),
    .stat0_o (stat0), .stat1_o (stat1), .en_stb_o (en_stb_o)
  );

endmodule

/* tb/gremlin_chk.sv */
`timescale 1ns/100ps

module gremlin_chk
(
  input logic                      CLK,
  input logic                      RST,
  input gremlin_pkg::sched_state_t state_i,
  input logic [1:0]                mcu_req_align_i,
  input logic                      mcu_refresh_stb_i,
  input logic                      blck_issue_i
);

  refresh_in_idle: assert property (@(posedge CLK) disable iff (!RST)
    (mcu_refresh_stb_i != $past(mcu_refresh_stb_i)) |->
      ($past(state_i) == gremlin_pkg::S_IDLE))
    else $error("refresh strobe toggled outside idle");

  // request held from grant wait until the mover finishes
  align_onehot: assert property (@(posedge CLK) disable iff (!RST)
    (state_i == gremlin_pkg::S_REQ || state_i == gremlin_pkg::S_RUN) |->
      $onehot(mcu_req_align_i))
    else $error("alignment request not one-hot during a transfer");

  issue_in_req: assert property (@(posedge CLK) disable iff (!RST)
    (blck_issue_i != $past(blck_issue_i)) |-> ($past(state_i) == gremlin_pkg::S_REQ))
    else $error("issue strobe toggled outside the request state");

endmodule

bind xfer_sched_fsm gremlin_chk gremlin_chk_i (
  .CLK (CLK), .RST (RST), .state_i (state_q),
  .mcu_req_align_i (mcu_req_align_o), .mcu_refresh_stb_i (mcu_refresh_stb_o),
  .blck_issue_i (blck_issue_o)
);

/* tb/tb_gremlin.sv */
`timescale 1ns/100ps

module tb_gremlin;

  localparam int SMALL_PERIOD = 24;
  localparam int SLOT1_TICK   = 12;
  localparam int N_XFER       = 40;
  localparam int IDLE_STRETCH = 2 * 16 * SMALL_PERIOD;  // two turns of the big counter
  localparam int CYCLE_LIMIT  = N_XFER * 80 + IDLE_STRETCH + 100;

  logic        CLK               = 1'b0;
  logic        RST               = 1'b0;
  logic        write_cpu_i       = 1'b0;
  logic        read_cpu_i        = 1'b0;
  logic        addr_cpu_i        = 1'b0;
  logic [63:0] in_cpu_i          = '0;
  logic [5:0]  blck_count_sent_i = '0;
  logic        blck_working_i    = 1'b0;
  logic        blck_irq_i        = 1'b0;
  logic        blck_abort_i      = 1'b0;
  logic [1:0]  mcu_grant_align_i = '0;
  logic        write_ack_o, read_ack_o, blck_issue_o, mcu_refresh_stb_o;
  logic [31:0] read_data_o;
  logic [11:0] blck_start_o;
  logic [5:0]  blck_count_req_o;
  logic [1:0]  blck_section_o, rst_mvblck_o, mcu_req_align_o;
  logic [19:0] mcu_page_addr_o;
  logic [3:0]  en_stb_o;

  // reference model state
  integer      seed = 1;
  logic [63:0] m_word [2];          // last host word per slot
  logic [7:0]  m_stat [2];          // {sent, irq, abort} per slot
  logic [1:0]  m_pend;
  logic [3:0]  m_en;
  logic [3:0]  m_big;
  logic [7:0]  mv_stat;
  logic [63:0] cur_word;
  logic [31:0] exp_rdata;
  logic        cur_slot, busy, w_prev, r_prev, exp_wack, exp_rack;
  logic        issue_prev, rfrs_prev, gnt_armed;
  int          m_small, mv_cnt, done_cd, gnt_wait;
  int          windows, toggles, issues, writes;
  int          cycles = 0;

  gremlin_top #(
    .SMALL_PERIOD (SMALL_PERIOD),
    .SLOT1_TICK   (SLOT1_TICK)
  ) gremlin_top_i (
    .CLK (CLK), .RST (RST),
    .write_cpu_i (write_cpu_i), .read_cpu_i (read_cpu_i), .addr_cpu_i (addr_cpu_i),
    .in_cpu_i (in_cpu_i), .write_ack_o (write_ack_o), .read_ack_o (read_ack_o),
    .read_data_o (read_data_o),
    .blck_start_o (blck_start_o), .blck_count_req_o (blck_count_req_o),
    .blck_section_o (blck_section_o), .blck_issue_o (blck_issue_o),
    .rst_mvblck_o (rst_mvblck_o), .blck_count_sent_i (blck_count_sent_i),
    .blck_working_i (blck_working_i), .blck_irq_i (blck_irq_i),
    .blck_abort_i (blck_abort_i),
    .mcu_page_addr_o (mcu_page_addr_o), .mcu_req_align_o (mcu_req_align_o),
    .mcu_grant_align_i (mcu_grant_align_i), .mcu_refresh_stb_o (mcu_refresh_stb_o),
    .en_stb_o (en_stb_o)
  );

  always #20 CLK = !CLK;

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  always @(posedge CLK)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
      stop_run("timeout: the run did not finish within the cycle limit");
  end

  // ----------------------------------------
  // reference model, mover and mcu models
  // ----------------------------------------
  always @(posedge CLK)
  begin
    if (!RST)
    begin
      m_pend    = 2'b00;
      m_en      = 4'b0000;
      m_stat[0] = '0;
      m_stat[1] = '0;
      m_small   = 1;  // slot 0 waits a full period
      m_big     = 4'd0;
      busy      = 1'b0;
      w_prev    = 1'b1;
      r_prev    = 1'b1;
      exp_wack  = 1'b0;
      exp_rack  = 1'b0;
      issue_prev = 1'b0;
      rfrs_prev = 1'b0;
      gnt_armed = 1'b0;
      mv_cnt    = 0;
      done_cd   = 0;
      windows   = 0;
      toggles   = 0;
      issues    = 0;
      writes    = 0;
    end
    else
    begin
      compare_value("write_ack_o", write_ack_o, exp_wack);
      compare_value("read_ack_o", read_ack_o, exp_rack);
      if (exp_rack)
        compare_value("read_data_o", read_data_o, exp_rdata);
      compare_value("en_stb_o", en_stb_o, m_en);
      if (!busy)
        compare_value("rst_mvblck_o", rst_mvblck_o, 2'b00);  // no transfer in flight
      if (mcu_refresh_stb_o != rfrs_prev)
      begin
        toggles++;
        if (toggles > windows)
          stop_run("more refresh toggles than refresh windows");
      end
      rfrs_prev = mcu_refresh_stb_o;

      exp_rack = read_cpu_i && !r_prev;  // status before any update in this cycle
      if (exp_rack)
        exp_rdata = {23'd0, m_pend[addr_cpu_i], m_stat[addr_cpu_i]};
      r_prev = read_cpu_i;

      // slot 0 tick wins, then slot 1
      if (!busy && ((m_small == 0 && m_pend[0]) || (m_small == SLOT1_TICK && m_pend[1])))
      begin
        cur_slot         = !(m_small == 0 && m_pend[0]);
        cur_word         = m_word[cur_slot];
        m_pend[cur_slot] = 1'b0;
        busy             = 1'b1;
      end

      if (done_cd > 0)
      begin
        done_cd--;
        if (done_cd == 0)  // status latched two cycles after working drops
        begin
          m_stat[cur_slot]       = mv_stat;
          m_en[cur_word[25:24]] = !m_en[cur_word[25:24]];
          busy                  = 1'b0;
        end
      end

      if (blck_issue_o != issue_prev)
      begin
        compare_value("blck_start_o", blck_start_o, cur_word[43:32]);
        compare_value("blck_count_req_o", blck_count_req_o, cur_word[31:26]);
        compare_value("blck_section_o", blck_section_o, cur_word[25:24]);
        compare_value("mcu_page_addr_o", mcu_page_addr_o, cur_word[63:44]);
        compare_value("mcu_req_align_o", mcu_req_align_o, cur_word[22] ? 2'b10 : 2'b01);
        compare_value("rst_mvblck_o", rst_mvblck_o, cur_word[23] ? 2'b10 : 2'b01);
        issues++;
        mv_cnt  = 1 + ($unsigned($random(seed)) % 8);
        mv_stat = 8'($random(seed));
        blck_working_i <= 1'b1;
        {blck_count_sent_i, blck_irq_i, blck_abort_i} <= mv_stat;
      end
      else if (mv_cnt > 0)
      begin
        mv_cnt--;
        if (mv_cnt == 0)
        begin
          blck_working_i <= 1'b0;
          done_cd = 2;
        end
      end
      issue_prev = blck_issue_o;

      if (mcu_req_align_o == 2'b00)
      begin
        mcu_grant_align_i <= 2'b00;
        gnt_armed = 1'b0;
      end
      else
      begin
        if (!gnt_armed)
        begin
          gnt_armed = 1'b1;
          gnt_wait  = $unsigned($random(seed)) % 4;  // grant latency 0..3
        end
        if (gnt_wait == 0)
          mcu_grant_align_i <= mcu_req_align_o;
        else
          gnt_wait--;
      end

      exp_wack = write_cpu_i && !w_prev;
      if (exp_wack)
      begin
        m_word[in_cpu_i[0]] = in_cpu_i;
        m_pend[in_cpu_i[0]] = 1'b1;
        writes++;
      end
      w_prev = write_cpu_i;

      if (m_small == 0 && m_big[0])
        windows++;
      if (m_small == SMALL_PERIOD - 1)
      begin
        m_small = 0;
        m_big   = m_big + 4'd1;
      end
      else
        m_small++;
    end
  end

  // ----------------------------------------
  // host traffic
  // ----------------------------------------
  initial
  begin
    int          n;
    int          gap;
    logic        slot;
    logic [63:0] word;
    repeat (10) @(posedge CLK);
    RST <= 1'b1;
    for (n = 0; n < N_XFER; n++)
    begin
      gap = $unsigned($random(seed)) % 16;
      repeat (gap) @(posedge CLK);
      while (m_pend == 2'b11)
        @(posedge CLK);
      slot = 1'($random(seed));
      if (m_pend[slot])
        slot = !slot;  // only free slots get a descriptor
      word    = {$random(seed), $random(seed)};
      word[0] = slot;
      @(posedge CLK);
      in_cpu_i    <= word;
      write_cpu_i <= 1'b1;
      @(posedge CLK);
      write_cpu_i <= 1'b0;
      if ($random(seed) % 2 == 0)
      begin
        read_cpu_i <= 1'b1;
        addr_cpu_i <= 1'($random(seed));
      end
      @(posedge CLK);
      read_cpu_i <= 1'b0;
    end

    while (m_pend != 2'b00 || busy)
      @(posedge CLK);
    repeat (IDLE_STRETCH) @(posedge CLK);
    while (m_small != SLOT1_TICK)  // away from any refresh window
      @(posedge CLK);
    compare_value("refresh toggles", toggles, windows);
    compare_value("issue count", issues, writes);
    for (n = 0; n < 2; n++)
    begin
      @(posedge CLK);
      read_cpu_i <= 1'b1;
      addr_cpu_i <= n[0];
      @(posedge CLK);
      read_cpu_i <= 1'b0;
      repeat (2) @(posedge CLK);
      compare_value("read_data_o[8]", read_data_o[8], 1'b0);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* all.f */
common/gremlin_pkg.sv
scheduler/carousel_timer.sv
scheduler/xfer_sched_fsm.sv
design/host_regs.sv
design/status_capture.sv
design/gremlin_top.sv
tb/gremlin_chk.sv
tb/tb_gremlin.sv

/* run.sh */
#!/bin/sh
# build and run the gremlin testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_gremlin -f all.f -o tb_gremlin
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_gremlin
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished"
exit 0
